// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/VtbElinkLoop: verilog.f *.sv
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module tbElinkLoop

run: obj_dir/VtbElinkLoop
	./obj_dir/VtbElinkLoop | tee /dev/stderr | grep -q "^Finished with no errors$$"

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module tbElinkLoop

clean:
	rm -rf obj_dir

// ==== codePkg.sv ====
package codePkg;

  // Bit 0 is a, first on the line; bits [5:0] = iedcba, [9:6] = jhgf
  typedef logic [9:0] codeWord_t;

  // Control characters
  localparam logic [7:0] K28_1 = 8'h3C;  // SOP
  localparam logic [7:0] K28_5 = 8'hBC;  // Idle
  localparam logic [7:0] K28_6 = 8'hDC;  // EOP

  // Comma abcdeif, stored with a in bit 0 and f in bit 6
  localparam logic [6:0] COMMA_NEG = 7'b1111100;  // 0011111 on the line
  localparam logic [6:0] COMMA_POS = 7'b0000011;  // 1100000 on the line

  // K28 6b block, RD- form, same storage order
  localparam logic [5:0] K28_SIX = 6'b111100;

  typedef struct packed {
    logic       isK;
    logic [7:0] dataByte;
    logic       codeErr;  // Not a valid code word
    logic       dispErr;  // Running disparity violated
  } rxChar_t;

  // 5b6b table, RD- column, returned in storage order
  function automatic logic [5:0] sixNeg(input logic [4:0] x);
    logic [5:0] c;  // Written as abcdei
    logic [5:0] r;
    case (x)
      5'd0:  c = 6'b100111;
      5'd1:  c = 6'b011101;
      5'd2:  c = 6'b101101;
      5'd3:  c = 6'b110001;
      5'd4:  c = 6'b110101;
      5'd5:  c = 6'b101001;
      5'd6:  c = 6'b011001;
      5'd7:  c = 6'b111000;
      5'd8:  c = 6'b111001;
      5'd9:  c = 6'b100101;
      5'd10: c = 6'b010101;
      5'd11: c = 6'b110100;
      5'd12: c = 6'b001101;
      5'd13: c = 6'b101100;
      5'd14: c = 6'b011100;
      5'd15: c = 6'b010111;
      5'd16: c = 6'b011011;
      5'd17: c = 6'b100011;
      5'd18: c = 6'b010011;
      5'd19: c = 6'b110010;
      5'd20: c = 6'b001011;
      5'd21: c = 6'b101010;
      5'd22: c = 6'b011010;
      5'd23: c = 6'b111010;
      5'd24: c = 6'b110011;
      5'd25: c = 6'b100110;
      5'd26: c = 6'b010110;
      5'd27: c = 6'b110110;
      5'd28: c = 6'b001110;
      5'd29: c = 6'b101110;
      5'd30: c = 6'b011110;
      default: c = 6'b101011;  // D.31
    endcase
    for (int b = 0; b < 6; b++)
    begin
      r[b] = c[5 - b];  // a to bit 0
    end
    return r;
  endfunction

  // 3b4b table, RD- column, alt picks A7 over P7
  function automatic logic [3:0] fourNeg(input logic [2:0] y, input logic alt);
    logic [3:0] c;  // Written as fghj
    logic [3:0] r;
    case (y)
      3'd0: c = 4'b1011;
      3'd1: c = 4'b1001;
      3'd2: c = 4'b0101;
      3'd3: c = 4'b1100;
      3'd4: c = 4'b1101;
      3'd5: c = 4'b1010;
      3'd6: c = 4'b0110;
      default: c = alt ? 4'b0111 : 4'b1110;
    endcase
    for (int b = 0; b < 4; b++)
    begin
      r[b] = c[3 - b];  // f to bit 0
    end
    return r;
  endfunction

endpackage

// ==== dec8b10b.sv ====
`timescale 1ns/1ps
module dec8b10b import codePkg::*; (
  input  logic      getDataTrig,
  input  logic      rstN,
  input  logic      wordStrobe,
  input  codeWord_t rxWord,
  output rxChar_t   rxChar,
  output logic      rxValid
);

  logic       rdRx;      // Running disparity, 1 = positive
  logic [5:0] c6;
  logic [3:0] c4;
  logic [3:0] c4Eff;     // 4b block as a data code
  logic [5:0] cand6;
  logic [3:0] cand4;
  logic [4:0] low5;
  logic [2:0] high3;
  logic       hit6;
  logic       hit4;
  logic       kHit;
  logic [2:0] ones6;
  logic [2:0] ones4;
  logic       rdUse;
  logic       rdMid;
  logic       rdNext;
  logic       dispBad;

  always_comb
  begin
    c6   = rxWord[5:0];
    c4   = rxWord[9:6];
    kHit = (c6 == K28_SIX) || (c6 == ~K28_SIX);
    low5 = 5'd28;
    hit6 = kHit;
    for (int k = 0; k < 32; k++)  // Reverse 5b6b by search
    begin
      cand6 = sixNeg(5'(k));
      if (c6 == cand6 || (c6 == ~cand6 && (3'($countones(cand6)) != 3'd3 || k == 7)))
      begin
        low5 = 5'(k);
        hit6 = 1'b1;
      end
    end

    c4Eff = (c6 == ~K28_SIX) ? ~c4 : c4;  // K28 after RD- flips its 4b code
    high3 = 3'd0;
    hit4  = 1'b0;
    for (int m = 0; m < 8; m++)
    begin
      cand4 = fourNeg(3'(m), 1'b0);
      if (c4Eff == cand4 || (c4Eff == ~cand4 && (3'($countones(cand4)) != 3'd2 || m == 3)))
      begin
        high3 = 3'(m);
        hit4  = 1'b1;
      end
    end
    cand4 = fourNeg(3'd7, 1'b1);  // A7
    if (c4Eff == cand4 || c4Eff == ~cand4)
    begin
      high3 = 3'd7;
      hit4  = 1'b1;
    end

    // Commas carry their own disparity, resync on them
    rdUse   = kHit ? (c6 != K28_SIX) : rdRx;
    ones6   = 3'($countones(c6));
    ones4   = 3'($countones(c4));
    rdMid   = (ones6 != 3'd3) ? !rdUse : rdUse;
    rdNext  = (ones4 != 3'd2) ? !rdMid : rdMid;
    dispBad = (ones6 > 3'd3 && rdUse) || (ones6 < 3'd3 && !rdUse) ||
              (ones4 > 3'd2 && rdMid) || (ones4 < 3'd2 && !rdMid);
  end

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      rxValid <= 1'b0;
      rdRx    <= 1'b0;  // Start negative
    end
    else
    begin
      rxValid <= wordStrobe;
      if (wordStrobe)
      begin
        rdRx <= rdNext;
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (wordStrobe)
    begin
      rxChar <= '{isK: kHit, dataByte: {high3, low5},
                  codeErr: !(hit6 && hit4), dispErr: dispBad};
    end
  end

endmodule

// ==== elinkLoopTop.sv ====
`timescale 1ns/1ps
module elinkLoopTop import elinkPkg::*, codePkg::*; (
  input  logic       getDataTrig,
  input  logic       rstN,
  input  logic       genEnable,
  output logic [1:0] serialData,  // Line slice, looped back
  output rxChar_t    rxChar,
  output logic       rxValid,
  output logic       rxLocked
);

  linkChar_t txChar;
  codeWord_t txWord;
  codeWord_t rxWord;
  logic      wordLoad;    // Symbol slot strobe on the transmit side
  logic      wordStrobe;  // Aligned word strobe on the receive side

  elinkPacketGen uPacketGen (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .genEnable   (genEnable),
    .wordLoad    (wordLoad),
    .txChar      (txChar)
  );

  enc8b10b uEnc (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wordLoad    (wordLoad),
    .txChar      (txChar),
    .txWord      (txWord)
  );

  elinkTxGearbox uTxGearbox (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .txWord      (txWord),
    .wordLoad    (wordLoad),
    .serialData  (serialData)
  );

  // Receive side taps the same slice
  elinkRxAligner uRxAligner (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .serialData  (serialData),
    .rxWord      (rxWord),
    .wordStrobe  (wordStrobe),
    .rxLocked    (rxLocked)
  );

  dec8b10b uDec (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wordStrobe  (wordStrobe),
    .rxWord      (rxWord),
    .rxChar      (rxChar),
    .rxValid     (rxValid)
  );

endmodule

// ==== elinkPacketGen.sv ====
`timescale 1ns/1ps
module elinkPacketGen import elinkPkg::*; (
  input  logic      getDataTrig,
  input  logic      rstN,
  input  logic      genEnable,
  input  logic      wordLoad,
  output linkChar_t txChar
);

  // State names the character currently on txChar
  typedef enum logic [1:0] {sSop, sData, sEop, sIdle} genState_t;

  genState_t        state;
  logic [CNT_W-1:0] symCnt;   // Position in data run or idle gap
  logic [7:0]       byteCnt;  // Runs across packets, wraps at 255

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      state   <= sIdle;  // Line starts with idle commas
      symCnt  <= '0;
      byteCnt <= 8'h00;
      txChar  <= '{kind: kIdle, dataByte: 8'h00};
    end
    else if (wordLoad)  // One character per symbol slot
    begin
      case (state)
        sSop:
        begin
          txChar  <= '{kind: kData, dataByte: byteCnt};
          byteCnt <= byteCnt + 8'd1;
          symCnt  <= '0;
          state   <= sData;
        end
        sData:
        begin
          if (symCnt == CNT_W'(PKT_LEN - 1))  // Last byte already out
          begin
            txChar <= '{kind: kEop, dataByte: 8'h00};
            state  <= sEop;
          end
          else
          begin
            txChar  <= '{kind: kData, dataByte: byteCnt};
            byteCnt <= byteCnt + 8'd1;
            symCnt  <= symCnt + 1'b1;
          end
        end
        sEop:
        begin
          txChar <= '{kind: kIdle, dataByte: 8'h00};
          symCnt <= '0;
          state  <= sIdle;
        end
        default:  // sIdle
        begin
          if (symCnt != CNT_W'(IDLE_GAP - 1))
          begin
            txChar <= '{kind: kIdle, dataByte: 8'h00};
            symCnt <= symCnt + 1'b1;
          end
          else if (genEnable)  // Packet start, enable sampled here only
          begin
            txChar <= '{kind: kSop, dataByte: 8'h00};
            state  <= sSop;
          end
          else
          begin
            txChar <= '{kind: kIdle, dataByte: 8'h00};  // Hold in gap
          end
        end
      endcase
    end
  end

endmodule

// ==== elinkPkg.sv ====
package elinkPkg;

  // Kind of a link character
  typedef enum logic [1:0] {
    kData,  // Payload byte
    kSop,   // Start of packet
    kEop,   // End of packet
    kIdle   // Filler between packets
  } charKind_t;

  // Delimiter plus byte pair, 10 bits
  typedef struct packed {
    charKind_t  kind;
    logic [7:0] dataByte;  // Only meaningful for kData
  } linkChar_t;

  // Packet framing
  localparam int PKT_LEN  = 8;  // Data bytes per packet
  localparam int IDLE_GAP = 4;  // Idles between packets

  // Serial slicing
  localparam int SLICES_PER_WORD = 5;  // 2-bit slices per code word
  localparam int SLICE_CNT_W     = $clog2(SLICES_PER_WORD);
  localparam int HIST_W          = 12;  // Aligner history depth

  // Generator symbol counter, covers data run and idle gap
  localparam int CNT_W = $clog2(PKT_LEN > IDLE_GAP ? PKT_LEN : IDLE_GAP);

endpackage

// ==== elinkRxAligner.sv ====
`timescale 1ns/1ps
module elinkRxAligner import elinkPkg::*, codePkg::*; (
  input  logic       getDataTrig,
  input  logic       rstN,
  input  logic [1:0] serialData,
  output codeWord_t  rxWord,
  output logic       wordStrobe,
  output logic       rxLocked
);

  logic [HIST_W-1:0]      hist;       // Oldest bit in bit 0
  logic [SLICE_CNT_W-1:0] phase;      // Slice phase of the word boundary
  logic                   offset;     // Bit offset of the word boundary
  logic [1:0]             commaHit;   // Per bit offset
  logic                   lastSlice;  // Full word sits in the history
  logic                   sameBound;
  logic                   realign;
  logic                   newOff;
  logic                   takeWord;
  logic                   wordOff;

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      hist <= '0;  // No stale line bits after reset
    end
    else
    begin
      hist <= {serialData, hist[HIST_W-1:2]};  // Newest slice at the top
    end
  end

  always_comb
  begin
    for (int o = 0; o < 2; o++)
    begin
      commaHit[o] = (hist[o +: 7] == COMMA_NEG) || (hist[o +: 7] == COMMA_POS);
    end
    newOff    = !commaHit[0];
    lastSlice = (phase == SLICE_CNT_W'(SLICES_PER_WORD - 1));
    sameBound = rxLocked && lastSlice && commaHit[offset];  // Comma where expected
    realign   = (|commaHit) && !sameBound;
    takeWord  = realign || (rxLocked && lastSlice);
    wordOff   = realign ? newOff : offset;
  end

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      phase      <= '0;
      offset     <= 1'b0;
      rxLocked   <= 1'b0;
      wordStrobe <= 1'b0;
    end
    else
    begin
      wordStrobe <= takeWord;
      if (realign)  // Comma fixes phase and offset
      begin
        phase    <= '0;
        offset   <= newOff;
        rxLocked <= 1'b1;
      end
      else
      begin
        phase <= lastSlice ? '0 : phase + 1'b1;
      end
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (takeWord)
    begin
      rxWord <= hist[wordOff +: 10];
    end
  end

endmodule

// ==== elinkTxGearbox.sv ====
`timescale 1ns/1ps
module elinkTxGearbox import elinkPkg::*, codePkg::*; (
  input  logic       getDataTrig,
  input  logic       rstN,
  input  codeWord_t  txWord,
  output logic       wordLoad,
  output logic [1:0] serialData
);

  logic [SLICE_CNT_W-1:0] sliceCnt;  // Modulo-5 slot position
  codeWord_t              shiftReg;  // Word on the line
  logic                   lastSlot;

  assign lastSlot = (sliceCnt == SLICE_CNT_W'(SLICES_PER_WORD - 1));

  // Load strobe one cycle ahead of the new word on the line
  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      sliceCnt <= SLICE_CNT_W'(SLICES_PER_WORD - 1);  // First strobe right after reset
      wordLoad <= 1'b0;
    end
    else
    begin
      sliceCnt <= lastSlot ? '0 : sliceCnt + 1'b1;
      wordLoad <= lastSlot;
    end
  end

  // Next word is encoded while this one shifts out
  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      shiftReg <= '0;  // Quiet line
    end
    else if (wordLoad)
    begin
      shiftReg <= txWord;
    end
    else
    begin
      shiftReg <= {2'b00, shiftReg[9:2]};  // Two bits per cycle
    end
  end

  // Bit a leads, as the lower bit of the slice
  assign serialData = shiftReg[1:0];

endmodule

// ==== enc8b10b.sv ====
`timescale 1ns/1ps
module enc8b10b import elinkPkg::*, codePkg::*; (
  input  logic      getDataTrig,
  input  logic      rstN,
  input  logic      wordLoad,
  input  linkChar_t txChar,
  output codeWord_t txWord
);

  logic       rd;         // Running disparity, 1 = positive
  logic       isK;
  logic [7:0] dIn;        // HGFEDCBA
  logic [4:0] low5;       // EDCBA
  logic [2:0] high3;      // HGF
  logic [5:0] c6;
  logic [3:0] c4;
  logic [2:0] ones6;
  logic [2:0] ones4;
  logic       rdMid;      // Disparity between sub-blocks
  logic       rdNext;
  logic       useAlt;

  always_comb
  begin
    isK = (txChar.kind != kData);
    case (txChar.kind)
      kSop:    dIn = K28_1;
      kEop:    dIn = K28_6;
      kIdle:   dIn = K28_5;
      default: dIn = txChar.dataByte;
    endcase
    low5  = dIn[4:0];
    high3 = dIn[7:5];

    // 5b6b, RD+ form is the complement for unbalanced codes and D.07
    c6 = isK ? K28_SIX : sixNeg(low5);
    if (rd && (3'($countones(c6)) != 3'd3 || (!isK && low5 == 5'd7)))
    begin
      c6 = ~c6;
    end
    ones6 = 3'($countones(c6));
    rdMid = (ones6 != 3'd3) ? !rd : rd;

    // A7 avoids a run of five in data
    useAlt = !isK && (high3 == 3'd7) &&
             ((!rdMid && (low5 == 5'd17 || low5 == 5'd18 || low5 == 5'd20)) ||
              (rdMid && (low5 == 5'd11 || low5 == 5'd13 || low5 == 5'd14)));
    c4 = fourNeg(high3, useAlt);
    if (isK)
    begin
      if (!rdMid)
      begin
        c4 = ~c4;  // K28.y flips the balanced 4b code
      end
    end
    else if (rdMid && (3'($countones(c4)) != 3'd2 || high3 == 3'd3))
    begin
      c4 = ~c4;
    end
    ones4  = 3'($countones(c4));
    rdNext = (ones4 != 3'd2) ? !rdMid : rdMid;

    txWord = {c4, c6};  // a ends up in bit 0
  end

  always_ff @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      rd <= 1'b0;  // Start negative
    end
    else if (wordLoad)  // Word taken by the gearbox
    begin
      rd <= rdNext;
    end
  end

endmodule

// ==== tbElinkLoop.sv ====
`timescale 1ns/1ps
module tbElinkLoop import elinkPkg::*, codePkg::*; ();

  localparam int PKT_CYCLES     = (PKT_LEN + 2 + IDLE_GAP) * SLICES_PER_WORD;  // 70
  localparam int FIRST_PKTS     = 6;
  localparam int WRAP_PKTS      = 256 / PKT_LEN + 2;  // Byte count past 255
  localparam int LOCK_LIMIT     = 30;
  // 34 packets to wrap, up to 6 in the enable gap, reset and relock, plus margin
  localparam int TIMEOUT_CYCLES = 50 * PKT_CYCLES;

  typedef enum logic [1:0] {mGap, mData, mEop} modelState_t;

  logic        getDataTrig = 1'b0;
  logic        rstN;
  logic        genEnable;
  logic [1:0]  serialData;
  rxChar_t     rxChar;
  logic        rxValid;
  logic        rxLocked;

  int          seed;
  int          gapPkts;
  int          resetDelay;
  int          valErrs = 0;
  int          protoErrs = 0;
  int          cycleCnt = 0;
  logic        rstNd = 1'b0;     // rstN one cycle back
  logic        idleOnly;         // Generator fully held off
  int          sinceRelease = 0;
  int          sinceValid = 0;
  logic        seenValid = 1'b0;

  // Reference model of the generator, stepped by received characters
  modelState_t mState;
  logic [7:0]  expByte;
  int          dataIdx;
  int          idleCnt;
  int          pktCnt = 0;
  logic        gotSop;
  logic        sopLegal;
  logic        expIsK;
  logic [7:0]  expData;

  elinkLoopTop i_dut (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .genEnable   (genEnable),
    .serialData  (serialData),
    .rxChar      (rxChar),
    .rxValid     (rxValid),
    .rxLocked    (rxLocked)
  );

  always #10 getDataTrig = ~getDataTrig;  // 20 ns period

  always_comb
  begin
    gotSop   = rxChar.isK && (rxChar.dataByte == K28_1);
    sopLegal = (idleCnt >= IDLE_GAP) && !idleOnly;  // Full gap seen
    case (mState)
      mData:
      begin
        expIsK  = 1'b0;
        expData = expByte;
      end
      mEop:
      begin
        expIsK  = 1'b1;
        expData = K28_6;
      end
      default:
      begin
        expIsK  = 1'b1;
        expData = (sopLegal && gotSop) ? K28_1 : K28_5;  // Idle unless SOP may start
      end
    endcase
  end

  always @(posedge getDataTrig)
  begin
    if (!rstN)
    begin
      mState  <= mGap;
      expByte <= 8'h00;     // Count restarts with the generator
      dataIdx <= 0;
      idleCnt <= IDLE_GAP;  // First SOP needs no idles before it
      pktCnt  <= 0;
    end
    else if (rxValid)
    begin
      case (mState)
        mData:
        begin
          expByte <= expByte + 8'd1;  // Wraps at 255
          dataIdx <= dataIdx + 1;
          if (dataIdx == PKT_LEN - 1)
          begin
            mState <= mEop;
          end
        end
        mEop:
        begin
          mState  <= mGap;
          idleCnt <= 0;
          pktCnt  <= pktCnt + 1;
        end
        default:
        begin
          if (gotSop)
          begin
            mState  <= mData;
            dataIdx <= 0;
          end
          else if (idleCnt < IDLE_GAP)
          begin
            idleCnt <= idleCnt + 1;
          end
        end
      endcase
    end
  end

  // Lock and strobe bookkeeping
  always @(posedge getDataTrig)
  begin
    cycleCnt <= cycleCnt + 1;
    rstNd    <= rstN;
    if (!rstN)
    begin
      sinceRelease <= 0;
      seenValid    <= 1'b0;
      sinceValid   <= 0;
    end
    else
    begin
      if (!rxLocked)
      begin
        sinceRelease <= sinceRelease + 1;
      end
      if (rxValid)
      begin
        seenValid  <= 1'b1;
        sinceValid <= 1;
      end
      else
      begin
        sinceValid <= sinceValid + 1;
      end
    end
  end

  resetQuiet: assert property (@(posedge getDataTrig)
    (cycleCnt > 0 && !rstNd) |-> (!rxValid && !rxLocked && serialData == 2'b00))
  else
  begin
    protoErrs = protoErrs + 1;
    $display("Receiver active or line not quiet during or just after reset");
  end

  lockInTime: assert property (@(posedge getDataTrig)
    (rstN && !rxLocked) |-> (sinceRelease != LOCK_LIMIT))
  else
  begin
    protoErrs = protoErrs + 1;
    $display("rxLocked not raised within %0d cycles of reset release", LOCK_LIMIT);
  end

  strobeSpacing: assert property (@(posedge getDataTrig)
    (rstN && seenValid) |-> (rxValid == (sinceValid == SLICES_PER_WORD)))
  else
  begin
    protoErrs = protoErrs + 1;
    $display("rxValid spacing broken, %0d cycles since the last pulse",
             $sampled(sinceValid));
  end

  charKind: assert property (@(posedge getDataTrig)
    (rstN && rxValid) |-> (rxChar.isK == expIsK))
  else
  begin
    valErrs = valErrs + 1;
    $display("** Error rxChar.isK: expected %h, got %h",
             $sampled(expIsK), $sampled(rxChar.isK));
  end

  charByte: assert property (@(posedge getDataTrig)
    (rstN && rxValid) |-> (rxChar.dataByte == expData))
  else
  begin
    valErrs = valErrs + 1;
    $display("** Error rxChar.dataByte: expected %h, got %h",
             $sampled(expData), $sampled(rxChar.dataByte));
  end

  noLineErrors: assert property (@(posedge getDataTrig)
    (rstN && rxValid) |-> (!rxChar.codeErr && !rxChar.dispErr))
  else
  begin
    valErrs = valErrs + 1;
    $display("** Error rxChar.codeErr,dispErr: expected 0,0, got %h,%h",
             $sampled(rxChar.codeErr), $sampled(rxChar.dispErr));
  end

  task automatic waitCycles(input int n);
    repeat (n) @(posedge getDataTrig);
  endtask

  task automatic waitPackets(input int n);
    while (pktCnt < n)
    begin
      @(posedge getDataTrig);
    end
  endtask

  task automatic printErrorCounts();
    $display("Error counts: %0d value, %0d protocol", valErrs, protoErrs);
  endtask

  always @(posedge getDataTrig)
  begin
    if (cycleCnt == TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, test sequence did not complete", cycleCnt);
      printErrorCounts();
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    seed      = 77;
    rstN      = 1'b0;
    genEnable = 1'b1;
    idleOnly  = 1'b0;
    waitCycles(5);
    rstN <= 1'b1;
    waitPackets(FIRST_PKTS);

    // Generator held off for a random number of packets
    gapPkts = 2 + int'($unsigned($random(seed)) % 3);
    genEnable <= 1'b0;
    waitCycles(2 * PKT_CYCLES);  // Packet already in flight drains
    idleOnly <= 1'b1;
    waitCycles(gapPkts * PKT_CYCLES);
    idleOnly  <= 1'b0;
    genEnable <= 1'b1;
    waitPackets(WRAP_PKTS);  // Long run, byte count wraps

    // Reset at a random point in a packet
    resetDelay = 1 + int'($unsigned($random(seed)) % PKT_CYCLES);
    waitCycles(resetDelay);
    rstN <= 1'b0;
    waitCycles(5);
    rstN <= 1'b1;
    waitPackets(2);

    printErrorCounts();
    if (valErrs + protoErrs == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
elinkPkg.sv
codePkg.sv
elinkPacketGen.sv
enc8b10b.sv
elinkTxGearbox.sv
elinkRxAligner.sv
dec8b10b.sv
elinkLoopTop.sv
tbElinkLoop.sv
